//--- include/blueprint_settings.svh
`ifndef BLUEPRINT_SETTINGS_SVH
`define BLUEPRINT_SETTINGS_SVH

// ----------------------------------------------------------------------
// Raster geometry
// ----------------------------------------------------------------------

`define H_TOTAL          320  // Pixels per line
`define H_ACTIVE         256  // First pixel of hblank
`define V_TOTAL          264  // Lines per frame
`define V_ACTIVE_START   16   // First visible line
`define V_ACTIVE_END     240  // First line of bottom vblank

// ----------------------------------------------------------------------
// Sync windows before centering
// ----------------------------------------------------------------------

`define HS_BASE          280  // Hsync start with zero offset
`define HS_WIDTH         32   // Hsync length in pixels
`define VS_BASE          248  // Vsync start with zero offset
`define VS_WIDTH         4    // Vsync length in lines

// Pixel enable as N/M of clk_49m, about 4.997 MHz
`define PIX_CEN_N        89
`define PIX_CEN_M        875

// ----------------------------------------------------------------------
// Channel levels
// ----------------------------------------------------------------------

`define LEVEL_FULL       31   // Normal tile pen and every sprite
`define LEVEL_DIM        24   // Tile pen with intensity bit set

`endif

//--- src/blueprint_pkg.sv
package blueprint_pkg;

	// Raster counters, 320 and 264 both need 9 bits
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// One colour channel towards the DAC
	typedef logic [4:0] level_t;

	// Pixel pair from the two tile bitplanes
	// 0 is transparent
	typedef logic [1:0] tile_pix_t;

	// Pen in RBG order
	// Bit 0 red, bit 1 blue, bit 2 green
	// Tile pens and sprite pixels share the layout
	typedef logic [2:0] rbg_t;

	// Tile colour latch as taken from colour RAM
	typedef struct packed {
		logic intensity;  // Bit 6 dims the tile pen
		rbg_t pen_hi;     // Bits 5..3 pen for pair value 2
		rbg_t pen_lo;     // Bits 2..0 pen for pair value 1
	} tile_color_t;

	// Colour channels named by their bit in rbg_t
	typedef enum logic [1:0] {
		CH_RED   = 2'd0,
		CH_BLUE  = 2'd1,
		CH_GREEN = 2'd2
	} channel_e;

endpackage

//--- src/frac_cen.sv
`timescale 1ns/1ps
`include "blueprint_settings.svh"

module frac_cen (
	input  logic clk_49m,
	input  logic reset,
	output logic cen_o
);

	// Accumulator holds M plus N without wrapping
	localparam int ACC_W = $clog2(`PIX_CEN_M + `PIX_CEN_N);
	localparam logic [ACC_W-1:0] STEP_N = ACC_W'(`PIX_CEN_N);
	localparam logic [ACC_W-1:0] MOD_M  = ACC_W'(`PIX_CEN_M);

	logic [ACC_W-1:0] acc;      // Phase in units of 1/M clock
	logic [ACC_W-1:0] acc_sum;  // Phase after this clock

	assign acc_sum = acc + STEP_N;

	// ----------------------------------------------------------------------
	// Phase accumulator
	// ----------------------------------------------------------------------

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			acc   <= '0;
			cen_o <= 1'b0;
		end else if (acc_sum >= MOD_M) begin
			acc   <= acc_sum - MOD_M;  // Keep the remainder for the next pulse
			cen_o <= 1'b1;
		end else begin
			acc   <= acc_sum;
			cen_o <= 1'b0;
		end
	end

	// N is well below M/2 so two enables always have a gap
	property p_cen_single;
		@(posedge clk_49m) disable iff (!reset)
			cen_o |=> !cen_o;
	endproperty

	a_cen_single: assert property (p_cen_single)
		else $error("frac_cen: pixel enable high on two adjacent clocks");

endmodule

//--- src/video_timing.sv
`timescale 1ns/1ps
`include "blueprint_settings.svh"

module video_timing (
	input  logic                   clk_49m,
	input  logic                   reset,
	input  logic                   cen_i,
	input  logic [3:0]             h_center_i,
	input  logic [3:0]             v_center_i,
	input  logic                   irq_ack_i,
	output blueprint_pkg::hcount_t hcount_o,
	output blueprint_pkg::vcount_t vcount_o,
	output logic                   hblank_o,
	output logic                   vblank_o,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   irq_n_o
);

	import blueprint_pkg::*;

	localparam hcount_t H_LAST      = hcount_t'(`H_TOTAL - 1);
	localparam vcount_t V_LAST      = vcount_t'(`V_TOTAL - 1);
	localparam hcount_t H_ACT       = hcount_t'(`H_ACTIVE);
	localparam vcount_t V_ACT_START = vcount_t'(`V_ACTIVE_START);
	localparam vcount_t V_ACT_END   = vcount_t'(`V_ACTIVE_END);

	hcount_t hs_start;  // Centred hsync window
	hcount_t hs_end;
	vcount_t vs_start;  // Centred vsync window
	vcount_t vs_end;
	logic    vblank_q;  // Vblank one clock ago for edge detect

	// ----------------------------------------------------------------------
	// Raster counters
	// ----------------------------------------------------------------------

	// 320 x 264, stepped by the pixel enable only
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			hcount_o <= '0;
			vcount_o <= '0;
		end else if (cen_i) begin
			if (hcount_o == H_LAST) begin
				hcount_o <= '0;
				vcount_o <= (vcount_o == V_LAST) ? '0 : vcount_o + 1'b1;  // Next line
			end else begin
				hcount_o <= hcount_o + 1'b1;
			end
		end
	end

	// Blanking straight from the counters
	assign hblank_o = (hcount_o >= H_ACT);
	assign vblank_o = (vcount_o < V_ACT_START) || (vcount_o >= V_ACT_END);

	// ----------------------------------------------------------------------
	// Sync with centering offsets
	// ----------------------------------------------------------------------

	// Worst case 280+15+32 still fits in 9 bits
	assign hs_start = hcount_t'(`HS_BASE) + hcount_t'(h_center_i);
	assign hs_end   = hs_start + hcount_t'(`HS_WIDTH);
	assign vs_start = vcount_t'(`VS_BASE) + vcount_t'(v_center_i);
	assign vs_end   = vs_start + vcount_t'(`VS_WIDTH);

	assign hsync_o = (hcount_o >= hs_start) && (hcount_o < hs_end);
	assign vsync_o = (vcount_o >= vs_start) && (vcount_o < vs_end);

	// ----------------------------------------------------------------------
	// Vblank interrupt request
	// ----------------------------------------------------------------------

	// Request set on the rising edge of vblank and held until acknowledged
	// vblank_q resets high because the raster starts inside vblank
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			irq_n_o  <= 1'b1;
			vblank_q <= 1'b1;
		end else begin
			vblank_q <= vblank_o;
			if (irq_ack_i)
				irq_n_o <= 1'b1;  // Ack beats a new edge
			else if (vblank_o && !vblank_q)
				irq_n_o <= 1'b0;
		end
	end

	// Horizontal counter stays inside the line
	a_hcount_range: assert property (
		@(posedge clk_49m) disable iff (!reset)
			hcount_o <= H_LAST
	) else $error("video_timing: hcount %0d past end of line", hcount_o);

endmodule

//--- src/pen_decode.sv
`timescale 1ns/1ps

module pen_decode (
	input  blueprint_pkg::tile_pix_t   tile_pix_i,
	input  blueprint_pkg::tile_color_t tile_color_i,
	input  logic                       tile_priority_i,
	input  blueprint_pkg::rbg_t        sprite_pix_i,
	output blueprint_pkg::rbg_t        pen_o,
	output blueprint_pkg::rbg_t        sprite_pix_o,
	output logic                       intensity_o,
	output logic                       use_sprite_o
);

	import blueprint_pkg::*;

	rbg_t pen_lo;         // Pen for pair value 1
	rbg_t pen_hi;         // Pen for pair value 2
	logic tile_opaque;    // Tile pixel is not pair 0
	logic sprite_opaque;  // Any sprite colour bit lit
	logic tile_wins;      // Priority tile covers the sprite

	assign pen_lo      = tile_color_i.pen_lo;
	assign pen_hi      = tile_color_i.pen_hi;
	assign intensity_o = tile_color_i.intensity;

	// ----------------------------------------------------------------------
	// Tile pen from pixel pair
	// ----------------------------------------------------------------------

	always_comb begin
		case (tile_pix_i)
			2'd0:    pen_o = '0;               // Transparent shows black
			2'd1:    pen_o = pen_lo;
			2'd2:    pen_o = pen_hi;
			default: pen_o = pen_lo | pen_hi;  // Both planes lit
		endcase
	end

	// ----------------------------------------------------------------------
	// Tile over sprite priority
	// ----------------------------------------------------------------------

	assign tile_opaque   = (tile_pix_i != 2'd0);
	assign sprite_opaque = (sprite_pix_i != '0);
	assign tile_wins     = tile_priority_i && tile_opaque;

	// Sprite shown unless transparent or under a priority tile
	assign use_sprite_o = sprite_opaque && !tile_wins;

	// Sprite colour goes on to the mixers unchanged
	assign sprite_pix_o = sprite_pix_i;

endmodule

//--- src/channel_mixer.sv
`timescale 1ns/1ps
`include "blueprint_settings.svh"

module channel_mixer #(
	parameter blueprint_pkg::channel_e CHANNEL = blueprint_pkg::CH_RED
) (
	input  blueprint_pkg::rbg_t   pen_i,
	input  blueprint_pkg::rbg_t   sprite_pix_i,
	input  logic                  intensity_i,
	input  logic                  use_sprite_i,
	output blueprint_pkg::level_t level_o
);

	import blueprint_pkg::*;

	localparam level_t FULL = level_t'(`LEVEL_FULL);
	localparam level_t DIM  = level_t'(`LEVEL_DIM);

	logic   sprite_bit;  // This channel in the sprite pixel
	logic   tile_bit;    // This channel in the tile pen
	level_t tile_level;  // Lit tile level after intensity

	// Channel enum value is the bit position in RBG order
	assign sprite_bit = sprite_pix_i[CHANNEL];
	assign tile_bit   = pen_i[CHANNEL];

	// Intensity only dims tiles
	assign tile_level = intensity_i ? DIM : FULL;

	// ----------------------------------------------------------------------
	// Level select
	// ----------------------------------------------------------------------

	always_comb begin
		if (use_sprite_i) begin
			level_o = sprite_bit ? FULL : '0;  // Sprites always full level
		end else begin
			level_o = tile_bit ? tile_level : '0;
		end
	end

endmodule

//--- src/video_out.sv
`timescale 1ns/1ps

module video_out (
	input  logic                  clk_49m,
	input  logic                  reset,
	input  logic                  cen_i,
	input  blueprint_pkg::level_t levels_i [3],
	input  logic                  hblank_i,
	input  logic                  vblank_i,
	input  logic                  hsync_i,
	input  logic                  vsync_i,
	output blueprint_pkg::level_t red_o,
	output blueprint_pkg::level_t green_o,
	output blueprint_pkg::level_t blue_o,
	output logic                  hblank_o,
	output logic                  vblank_o,
	output logic                  hsync_o,
	output logic                  vsync_o,
	output logic                  csync_o
);

	import blueprint_pkg::*;

	logic blank;  // Either blanking interval

	assign blank = hblank_i | vblank_i;

	// ----------------------------------------------------------------------
	// Pixel output register
	// ----------------------------------------------------------------------

	// One pixel enable of latency for colour and sync alike
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			red_o    <= '0;
			green_o  <= '0;
			blue_o   <= '0;
			hblank_o <= 1'b0;
			vblank_o <= 1'b0;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			csync_o  <= 1'b0;
		end else if (cen_i) begin
			red_o    <= blank ? '0 : levels_i[CH_RED];    // Black in blanking
			green_o  <= blank ? '0 : levels_i[CH_GREEN];
			blue_o   <= blank ? '0 : levels_i[CH_BLUE];
			hblank_o <= hblank_i;
			vblank_o <= vblank_i;
			hsync_o  <= hsync_i;
			vsync_o  <= vsync_i;
			csync_o  <= ~(hsync_i ^ vsync_i);              // Composite as XNOR
		end
	end

endmodule

//--- src/blueprint_video.sv
`timescale 1ns/1ps

module blueprint_video (
	input  logic                       clk_49m,
	input  logic                       reset,
	input  logic [3:0]                 h_center_i,
	input  logic [3:0]                 v_center_i,
	input  logic                       irq_ack_i,
	input  blueprint_pkg::tile_pix_t   tile_pix_i,
	input  blueprint_pkg::tile_color_t tile_color_i,
	input  logic                       tile_priority_i,
	input  blueprint_pkg::rbg_t        sprite_pix_i,
	output blueprint_pkg::level_t      red_o,
	output blueprint_pkg::level_t      green_o,
	output blueprint_pkg::level_t      blue_o,
	output logic                       hsync_o,
	output logic                       vsync_o,
	output logic                       csync_o,
	output logic                       hblank_o,
	output logic                       vblank_o,
	output logic                       ce_pix_o,
	output logic                       irq_n_o
);

	import blueprint_pkg::*;

	logic   cen_pix;     // ~5 MHz pixel enable
	logic   hblank;      // Raster state before the output register
	logic   vblank;
	logic   hsync;
	logic   vsync;
	rbg_t   pen;         // Decoded tile pen
	rbg_t   sprite_pix;
	logic   intensity;
	logic   use_sprite;
	level_t levels [3];  // Indexed by channel_e

	// ----------------------------------------------------------------------
	// Pixel clock and raster
	// ----------------------------------------------------------------------

	frac_cen u_pix_cen (
		.clk_49m (clk_49m),
		.reset   (reset),
		.cen_o   (cen_pix)
	);

	assign ce_pix_o = cen_pix;

	// Raster position stays inside the timing block
	video_timing u_timing (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.cen_i      (cen_pix),
		.h_center_i (h_center_i),
		.v_center_i (v_center_i),
		.irq_ack_i  (irq_ack_i),
		.hcount_o   (),
		.vcount_o   (),
		.hblank_o   (hblank),
		.vblank_o   (vblank),
		.hsync_o    (hsync),
		.vsync_o    (vsync),
		.irq_n_o    (irq_n_o)
	);

	// ----------------------------------------------------------------------
	// Colour path
	// ----------------------------------------------------------------------

	pen_decode u_pen (
		.tile_pix_i      (tile_pix_i),
		.tile_color_i    (tile_color_i),
		.tile_priority_i (tile_priority_i),
		.sprite_pix_i    (sprite_pix_i),
		.pen_o           (pen),
		.sprite_pix_o    (sprite_pix),
		.intensity_o     (intensity),
		.use_sprite_o    (use_sprite)
	);

	// One mixer per channel in RBG order
	for (genvar k = 0; k < 3; k++) begin : g_channel
		channel_mixer #(
			.CHANNEL (channel_e'(k))
		) u_mixer (
			.pen_i        (pen),
			.sprite_pix_i (sprite_pix),
			.intensity_i  (intensity),
			.use_sprite_i (use_sprite),
			.level_o      (levels[k])
		);
	end

	video_out u_out (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.cen_i    (cen_pix),
		.levels_i (levels),
		.hblank_i (hblank),
		.vblank_i (vblank),
		.hsync_i  (hsync),
		.vsync_i  (vsync),
		.red_o    (red_o),
		.green_o  (green_o),
		.blue_o   (blue_o),
		.hblank_o (hblank_o),
		.vblank_o (vblank_o),
		.hsync_o  (hsync_o),
		.vsync_o  (vsync_o),
		.csync_o  (csync_o)
	);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic reset_o
);

	// 20 ns period
	initial clk_o = 1'b0;
	always #10 clk_o = ~clk_o;

	// Active low reset, released on a rising edge
	initial begin
		reset_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b1;
	end

endmodule

//--- test/blueprint_video_tb.sv
`timescale 1ns/1ps
`include "blueprint_settings.svh"

module blueprint_video_tb;

	import blueprint_pkg::*;

	// One stimulus row with the colour it should produce
	typedef struct packed {
		tile_pix_t   pair;
		tile_color_t color;
		logic        prio;
		rbg_t        sprite;
		level_t      red;
		level_t      green;
		level_t      blue;
	} row_t;

	localparam longint FRAME_CLKS = longint'(`H_TOTAL) * `V_TOTAL * `PIX_CEN_M / `PIX_CEN_N;
	localparam int     N_RANDOM   = 48;
	localparam level_t FULL       = level_t'(`LEVEL_FULL);
	localparam level_t DIM        = level_t'(`LEVEL_DIM);

	logic        clk_49m;
	logic        reset;
	logic [3:0]  h_center;
	logic [3:0]  v_center;
	logic        irq_ack;
	tile_pix_t   tile_pix;
	tile_color_t tile_color;
	logic        tile_priority;
	rbg_t        sprite_pix;
	level_t      red;
	level_t      green;
	level_t      blue;
	logic        hsync;
	logic        vsync;
	logic        csync;
	logic        hblank;
	logic        vblank;
	logic        ce_pix;
	logic        irq_n;

	int   h_pos;              // Raster position from counted enables
	int   v_pos;
	int   out_h;              // Position now held in the output register
	int   out_v;
	int   out_hc;             // Centering seen with that position
	int   out_vc;
	logic out_valid = 1'b0;
	logic exp_hs;
	logic exp_vs;
	int   hs_hits [2] = '{0, 0};  // Sync pixels per centering value
	int   vs_hits [2] = '{0, 0};
	int   error_count = 0;
	int   check_count = 0;
	int   mark_errors = 0;
	int   mark_checks = 0;
	row_t rows [$];

	tb_clock u_clock (
		.clk_o   (clk_49m),
		.reset_o (reset)
	);

	blueprint_video DUT (
		.clk_49m         (clk_49m),
		.reset           (reset),
		.h_center_i      (h_center),
		.v_center_i      (v_center),
		.irq_ack_i       (irq_ack),
		.tile_pix_i      (tile_pix),
		.tile_color_i    (tile_color),
		.tile_priority_i (tile_priority),
		.sprite_pix_i    (sprite_pix),
		.red_o           (red),
		.green_o         (green),
		.blue_o          (blue),
		.hsync_o         (hsync),
		.vsync_o         (vsync),
		.csync_o         (csync),
		.hblank_o        (hblank),
		.vblank_o        (vblank),
		.ce_pix_o        (ce_pix),
		.irq_n_o         (irq_n)
	);

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------

	function automatic logic is_blanked(input int h, input int v);
		return (h >= `H_ACTIVE) || (v < `V_ACTIVE_START) || (v >= `V_ACTIVE_END);
	endfunction

	// Expected colour straight from the pen and priority rules
	function automatic row_t model_row(input tile_pix_t pair, input tile_color_t color,
			input logic prio, input rbg_t sprite);
		row_t   r;
		rbg_t   lit;
		level_t lvl;
		r.pair   = pair;
		r.color  = color;
		r.prio   = prio;
		r.sprite = sprite;
		if (sprite != 3'b000 && !(prio && pair != 2'd0)) begin
			lit = sprite;  // Sprite shown at full level
			lvl = FULL;
		end else begin
			// Bit 0 of the pair picks the low pen, bit 1 the high pen
			lit = (pair[0] ? color.pen_lo : 3'b000) | (pair[1] ? color.pen_hi : 3'b000);
			lvl = color.intensity ? DIM : FULL;
		end
		r.red   = lit[0] ? lvl : 5'd0;
		r.blue  = lit[1] ? lvl : 5'd0;
		r.green = lit[2] ? lvl : 5'd0;
		return r;
	endfunction

	// Counts enables like the raster counters and tracks the output register
	always @(posedge clk_49m) begin
		if (!reset) begin
			h_pos     <= 0;
			v_pos     <= 0;
			out_valid <= 1'b0;
		end else if (ce_pix) begin
			out_h     <= h_pos;
			out_v     <= v_pos;
			out_hc    <= h_center;
			out_vc    <= v_center;
			out_valid <= 1'b1;
			if (h_pos == `H_TOTAL - 1) begin
				h_pos <= 0;
				v_pos <= (v_pos == `V_TOTAL - 1) ? 0 : v_pos + 1;  // Next line
			end else begin
				h_pos <= h_pos + 1;
			end
		end
	end

	// Sync and blank flags checked on every clock once a pixel is out
	always @(negedge clk_49m) begin
		if (out_valid) begin
			exp_hs = (out_h >= `HS_BASE + out_hc) && (out_h < `HS_BASE + out_hc + `HS_WIDTH);
			exp_vs = (out_v >= `VS_BASE + out_vc) && (out_v < `VS_BASE + out_vc + `VS_WIDTH);
			if (exp_hs)
				hs_hits[(out_hc != 0) ? 1 : 0]++;
			if (exp_vs)
				vs_hits[(out_vc != 0) ? 1 : 0]++;
			check_count++;
			assert (hsync === exp_hs && vsync === exp_vs && csync === (exp_hs == exp_vs)
					&& hblank === (out_h >= `H_ACTIVE)
					&& vblank === is_blanked(0, out_v)) else begin
				$display("mismatch at %0t ns: flags h=%0d v=%0d hs=%b vs=%b cs=%b hb=%b vb=%b",
					$time, out_h, out_v, hsync, vsync, csync, hblank, vblank);
				error_count++;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Tasks
	// ----------------------------------------------------------------------

	task automatic wait_enable();
		@(negedge clk_49m);
		while (!ce_pix) @(negedge clk_49m);
	endtask

	task automatic wait_line(input int line);
		@(negedge clk_49m);
		while (v_pos != line) @(negedge clk_49m);
	endtask

	// Drive after one enable, hold over the next, check the registered result
	task automatic apply_row(input row_t r, input int idx);
		logic   blanked;
		level_t exp_r;
		level_t exp_g;
		level_t exp_b;
		wait_enable();
		@(posedge clk_49m);
		tile_pix      <= r.pair;
		tile_color    <= r.color;
		tile_priority <= r.prio;
		sprite_pix    <= r.sprite;
		wait_enable();
		@(posedge clk_49m);  // Output register loads here
		@(negedge clk_49m);
		blanked = is_blanked(out_h, out_v);
		exp_r   = blanked ? 5'd0 : r.red;
		exp_g   = blanked ? 5'd0 : r.green;
		exp_b   = blanked ? 5'd0 : r.blue;
		check_count++;
		assert (red === exp_r && green === exp_g && blue === exp_b) else begin
			$display("mismatch at %0t ns: row %0d h=%0d v=%0d rgb %0d/%0d/%0d exp %0d/%0d/%0d",
				$time, idx, out_h, out_v, red, green, blue, exp_r, exp_g, exp_b);
			error_count++;
		end
	endtask

	task automatic check_irq(input logic expected, input string what);
		check_count++;
		assert (irq_n === expected) else begin
			$display("mismatch at %0t ns: irq_n_o is %b %s", $time, irq_n, what);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			check_count - mark_checks, error_count - mark_errors);
		mark_checks = check_count;
		mark_errors = error_count;
	endtask

	// ----------------------------------------------------------------------
	// Watchdog over two frames of pixel enables
	// ----------------------------------------------------------------------

	initial begin
		#(2 * FRAME_CLKS * 20);
		$display("timeout: the run did not finish within two frames of pixel enables");
		$display("Test failures found");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------

	initial begin
		int   enables;
		row_t white;
		void'($urandom(32'h3c94449f));
		h_center      = 4'd0;
		v_center      = 4'd0;
		irq_ack       = 1'b0;
		tile_pix      = '0;
		tile_color    = '0;
		tile_priority = 1'b0;
		sprite_pix    = '0;
		white         = model_row(2'd3, 7'b0_111_111, 1'b0, 3'b000);

		// pair, latch {int, hi, lo}, prio, sprite, red, green, blue
		rows.push_back('{2'd0, 7'b0_110_001, 1'b0, 3'b000, 5'd0, 5'd0, 5'd0});
		rows.push_back('{2'd1, 7'b0_110_001, 1'b0, 3'b000, 5'd31, 5'd0, 5'd0});
		rows.push_back('{2'd2, 7'b0_110_001, 1'b0, 3'b000, 5'd0, 5'd31, 5'd31});
		rows.push_back('{2'd3, 7'b0_110_001, 1'b0, 3'b000, 5'd31, 5'd31, 5'd31});
		rows.push_back('{2'd1, 7'b1_010_100, 1'b0, 3'b000, 5'd0, 5'd24, 5'd0});
		rows.push_back('{2'd2, 7'b1_010_100, 1'b0, 3'b000, 5'd0, 5'd0, 5'd24});
		rows.push_back('{2'd3, 7'b1_010_100, 1'b0, 3'b000, 5'd0, 5'd24, 5'd24});
		rows.push_back('{2'd0, 7'b1_010_100, 1'b0, 3'b000, 5'd0, 5'd0, 5'd0});
		rows.push_back('{2'd1, 7'b0_000_001, 1'b1, 3'b100, 5'd31, 5'd0, 5'd0});  // Tile on top
		rows.push_back('{2'd1, 7'b0_000_001, 1'b0, 3'b100, 5'd0, 5'd31, 5'd0});
		rows.push_back('{2'd0, 7'b0_000_001, 1'b1, 3'b010, 5'd0, 5'd0, 5'd31});
		rows.push_back('{2'd2, 7'b1_011_000, 1'b0, 3'b000, 5'd24, 5'd0, 5'd24});
		rows.push_back('{2'd3, 7'b1_001_010, 1'b1, 3'b111, 5'd24, 5'd0, 5'd24});
		rows.push_back('{2'd3, 7'b1_001_010, 1'b0, 3'b111, 5'd31, 5'd31, 5'd31});
		rows.push_back('{2'd1, 7'b1_000_111, 1'b0, 3'b001, 5'd31, 5'd0, 5'd0});
		rows.push_back('{2'd0, 7'b1_111_111, 1'b0, 3'b000, 5'd0, 5'd0, 5'd0});
		repeat (N_RANDOM)
			rows.push_back(model_row(tile_pix_t'($urandom), tile_color_t'($urandom),
				1'($urandom), rbg_t'($urandom)));

		// Enable rate over four full accumulator periods
		@(negedge clk_49m);
		while (!reset) @(negedge clk_49m);
		enables = 0;
		repeat (4 * `PIX_CEN_M) begin
			@(negedge clk_49m);
			enables += ce_pix;
		end
		check_count++;
		assert (enables == 4 * `PIX_CEN_N) else begin
			$display("mismatch at %0t ns: %0d pixel enables in %0d clocks, expected %0d",
				$time, enables, 4 * `PIX_CEN_M, 4 * `PIX_CEN_N);
			error_count++;
		end
		finish_test("pixel enable rate");

		// White pixels in the top vblank must come out black
		repeat (3) apply_row(white, -3);
		finish_test("top vblank blanking");

		// Colour rows on a visible line
		wait_line(20);
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(rows[i], i);
			if (i == 7)
				finish_test("tile pens");
		end
		finish_test("priority and random rows");

		// White pixels inside hblank must come out black
		while (h_pos != `H_ACTIVE + 2) @(negedge clk_49m);
		repeat (3) apply_row(white, -1);
		finish_test("hblank blanking");

		wait_line(`V_ACTIVE_END - 1);
		check_irq(1'b1, "before the bottom vblank");
		wait_line(`V_ACTIVE_END);
		check_irq(1'b1, "in the clock where vblank rises");
		@(negedge clk_49m);
		check_irq(1'b0, "one clock after vblank rises");
		repeat (500) @(negedge clk_49m);
		check_irq(1'b0, "while waiting for the acknowledge");
		@(posedge clk_49m);
		irq_ack <= 1'b1;
		@(negedge clk_49m);
		check_irq(1'b0, "before the acknowledge is sampled");
		@(posedge clk_49m);
		irq_ack <= 1'b0;
		@(negedge clk_49m);
		check_irq(1'b1, "one clock after the acknowledge");
		repeat (500) @(negedge clk_49m);
		check_irq(1'b1, "after the acknowledge with vblank still high");
		finish_test("vblank interrupt");

		// Same white pixels in the bottom vblank
		repeat (3) apply_row(white, -2);
		finish_test("bottom vblank blanking");

		// Second centering value after the first vsync window
		wait_line(252);
		@(posedge clk_49m);
		h_center <= 4'd6;
		v_center <= 4'd9;
		wait_line(262);
		check_count++;
		assert (hs_hits[0] > 0 && hs_hits[1] > 0
				&& vs_hits[0] > 0 && vs_hits[1] > 0) else begin
			$display("sync windows were not reached for both centering values");
			error_count++;
		end
		finish_test("sync windows");

		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
src/blueprint_pkg.sv
src/frac_cen.sv
src/video_timing.sv
src/pen_decode.sv
src/channel_mixer.sv
src/video_out.sv
src/blueprint_video.sv
test/tb_clock.sv
test/blueprint_video_tb.sv
